// ==== build.f ====
+incdir+include
design/burst_cfg_pkg.sv
design/burst_rule_pkg.sv
design/slave_cmd_if.sv
design/burst_gearbox.sv
design/burst_cmd_tracker.sv
design/burst_bridge_top.sv
tests/burst_bridge_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the burst count bridge
# The simulation is built and run once with natural alignment and once without

.PHONY: lint sim sim_aligned sim_unaligned clean

lint:
	verilator --lint-only --timing -f build.f --top-module burst_bridge_tb

sim: sim_aligned sim_unaligned

sim_aligned:
	verilator --binary --timing --assert -f build.f --top-module burst_bridge_tb \
		-GNATURAL_ALIGNMENT=1 --Mdir obj_aligned -o burst_bridge_sim
	@out="$$(./obj_aligned/burst_bridge_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "Testbench passed"

sim_unaligned:
	verilator --binary --timing --assert -f build.f --top-module burst_bridge_tb \
		-GNATURAL_ALIGNMENT=0 --Mdir obj_unaligned -o burst_bridge_sim
	@out="$$(./obj_unaligned/burst_bridge_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_aligned obj_unaligned

// ==== include/burst_ref_model.svh ====
// Reference model of the burst splitting
// Turns one master command into the list of slave pieces that the
// bridge is expected to issue, one address and one size per piece

`ifndef BURST_REF_MODEL_SVH
`define BURST_REF_MODEL_SVH

    // Expected pieces of the command in progress, in issue order
    logic [ADDR_WIDTH-1:0] model_addr_q[$];
    int                    model_size_q[$];

    // Size of the next piece for a start address and the flits still left
    function automatic int next_piece_size(
        input logic [ADDR_WIDTH-1:0] addr,
        input int                    remaining
    );
        int size;
        if (NATURAL_ALIGNMENT != 0)
        begin
            // Start from the slave maximum and halve until the piece
            // fits in the remainder and the address is a multiple of it
            size = SLAVE_MAX;
            while (size > remaining)
            begin
                size = size / 2;
            end
            while ((addr % ADDR_WIDTH'(size)) != '0)
            begin
                size = size / 2;
            end
        end
        else
        begin
            size = (remaining < SLAVE_MAX) ? remaining : SLAVE_MAX;
        end
        return size;
    endfunction

    // Fill the expected piece list for one master command
    function automatic void build_piece_list(
        input logic [ADDR_WIDTH-1:0] addr,
        input int                    count
    );
        logic [ADDR_WIDTH-1:0] cur_addr;
        int                    remaining;
        int                    size;
        model_addr_q.delete();
        model_size_q.delete();
        cur_addr  = addr;
        remaining = count;
        while (remaining > 0)
        begin
            size = next_piece_size(cur_addr, remaining);
            model_addr_q.push_back(cur_addr);
            model_size_q.push_back(size);
            // Pieces are back to back in the address space
            cur_addr  = cur_addr + ADDR_WIDTH'(size);
            remaining = remaining - size;
        end
    endfunction

`endif

// ==== tests/burst_bridge_tb.sv ====
// Testbench for the burst count bridge
// Sends random master commands, applies random slave back-pressure and
// checks each slave piece, the latency and the piece count against a model

`timescale 1ns/100ps

module burst_bridge_tb
    import burst_cfg_pkg::*;
#(
    parameter int NATURAL_ALIGNMENT = DEFAULT_NATURAL_ALIGNMENT
);

    localparam int ADDR_WIDTH         = DEFAULT_ADDR_WIDTH;
    localparam int MASTER_BURST_WIDTH = DEFAULT_MASTER_BURST_WIDTH;
    localparam int SLAVE_BURST_WIDTH  = DEFAULT_SLAVE_BURST_WIDTH;
    localparam int SLAVE_MAX          = 2 ** (SLAVE_BURST_WIDTH - 1);
    localparam int MAX_COUNT          = 2 ** (MASTER_BURST_WIDTH - 1);
    localparam int CLK_PERIOD         = 8;
    localparam int NUM_COMMANDS       = 300;
    localparam int CYCLES_PER_COMMAND = 70;

    logic                          clk;
    logic                          reset_n;
    logic                          m_new_req;
    logic [ADDR_WIDTH-1:0]         m_addr;
    logic [MASTER_BURST_WIDTH-1:0] m_burstcount;
    logic                          busy;
    logic                          s_valid;
    logic [ADDR_WIDTH-1:0]         s_addr;
    logic [SLAVE_BURST_WIDTH-1:0]  s_burstcount;
    logic                          s_last;
    logic                          s_accept;
    logic [PIECE_COUNT_WIDTH-1:0]  piece_count;

    int    seed;
    int    error_count;
    int    check_count;
    int    tests_run;
    int    tests_failed;
    int    errors_at_start;
    int    checks_at_start;
    int    current_command;
    string test_name;

    `include "burst_ref_model.svh"

    burst_bridge_top #(
        .ADDR_WIDTH         (ADDR_WIDTH),
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH  (SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT  (NATURAL_ALIGNMENT)
    ) burst_bridge_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .m_new_req    (m_new_req),
        .m_addr       (m_addr),
        .m_burstcount (m_burstcount),
        .busy         (busy),
        .s_valid      (s_valid),
        .s_addr       (s_addr),
        .s_burstcount (s_burstcount),
        .s_last       (s_last),
        .s_accept     (s_accept),
        .piece_count  (piece_count)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Every command gets a generous cycle budget, so a stuck handshake ends the run
    initial
    begin
        #(NUM_COMMANDS * CYCLES_PER_COMMAND * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns",
                 NUM_COMMANDS * CYCLES_PER_COMMAND * CLK_PERIOD);
        $display("Testbench failed");
        $finish;
    end

    // Non-negative random number below limit
    function automatic int random_below(input int limit);
        int value;
        value = $random(seed) & 32'h7fff_ffff;
        return value % limit;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("Mismatch %s, command %0d, %s: expected %0h actual %0h",
                     test_name, current_command, what, expected, actual);
        end
    endtask

    task automatic require_true(input logic condition, input string text);
        check_count++;
        assert (condition)
        else
        begin
            error_count++;
            $display("Error in %s, command %0d: %s", test_name, current_command, text);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        checks_at_start = check_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == errors_at_start)
        begin
            $display("Test %s: ok after %0d checks", test_name, check_count - checks_at_start);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // One master command from the strobe until busy has fallen again
    task automatic run_command();
        logic [ADDR_WIDTH-1:0]        addr;
        logic [ADDR_WIDTH-1:0]        next_addr;
        logic [ADDR_WIDTH-1:0]        held_addr;
        logic [SLAVE_BURST_WIDTH-1:0] held_size;
        logic                         held_last;
        logic                         held;
        logic                         done;
        int                           count;
        int                           piece_index;
        int                           flit_sum;
        addr  = ADDR_WIDTH'($random(seed));
        count = random_below(MAX_COUNT) + 1;
        build_piece_list(addr, count);
        @(posedge clk);
        m_new_req    <= 1'b1;
        m_addr       <= addr;
        m_burstcount <= MASTER_BURST_WIDTH'(count);
        s_accept     <= 1'b0;
        @(negedge clk);
        check_value("s_valid in strobe cycle", 32'(0), 32'(s_valid));
        // The bridge loads the command on this edge
        @(posedge clk);
        m_new_req <= 1'b0;
        s_accept  <= (random_below(100) < 60);
        @(negedge clk);
        check_value("s_valid one cycle after strobe", 32'(1), 32'(s_valid));
        check_value("busy one cycle after strobe", 32'(1), 32'(busy));
        piece_index = 0;
        flit_sum    = 0;
        next_addr   = addr;
        held        = 1'b0;
        done        = 1'b0;
        while (!done)
        begin
            // A piece that was refused last cycle must still be on offer unchanged
            if (held)
            begin
                check_value("held s_addr", 32'(held_addr), 32'(s_addr));
                check_value("held s_burstcount", 32'(held_size), 32'(s_burstcount));
                check_value("held s_last", 32'(held_last), 32'(s_last));
            end
            check_value("piece_count", 32'(piece_index), 32'(piece_count));
            check_value("busy while pieces remain", 32'(1), 32'(busy));
            require_true(s_valid, "s_valid dropped before the last piece was accepted");
            if (!s_valid)
            begin
                done = 1'b1;
            end
            else if (s_accept)
            begin
                require_true(piece_index < model_size_q.size(),
                             "the bridge offered more pieces than the command needs");
                if (piece_index >= model_size_q.size())
                begin
                    done = 1'b1;
                end
                else
                begin
                    check_value("s_addr", 32'(model_addr_q[piece_index]), 32'(s_addr));
                    check_value("s_burstcount", 32'(model_size_q[piece_index]),
                                32'(s_burstcount));
                    check_value("contiguous s_addr", 32'(next_addr), 32'(s_addr));
                    check_value("s_last", 32'(piece_index == model_size_q.size() - 1),
                                32'(s_last));
                    next_addr   = next_addr + ADDR_WIDTH'(model_size_q[piece_index]);
                    flit_sum    = flit_sum + int'(s_burstcount);
                    piece_index = piece_index + 1;
                    done        = s_last;
                end
            end
            held      = !s_accept;
            held_addr = s_addr;
            held_size = s_burstcount;
            held_last = s_last;
            if (!done)
            begin
                @(posedge clk);
                s_accept <= (random_below(100) < 60);
                @(negedge clk);
            end
        end
        // The last piece leaves on this edge, so the bridge goes idle
        @(posedge clk);
        s_accept <= 1'b0;
        @(negedge clk);
        check_value("busy after last piece", 32'(0), 32'(busy));
        check_value("s_valid after last piece", 32'(0), 32'(s_valid));
        check_value("final piece_count", 32'(model_size_q.size()), 32'(piece_count));
        check_value("flits covered", 32'(count), 32'(flit_sum));
    endtask

    initial
    begin
        seed            = 26;
        error_count     = 0;
        check_count     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        current_command = 0;
        reset_n         = 1'b0;
        m_new_req       = 1'b0;
        m_addr          = '0;
        m_burstcount    = '0;
        s_accept        = 1'b0;
        $display("Running with NATURAL_ALIGNMENT = %0d", NATURAL_ALIGNMENT);
        start_test("reset");
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("busy after reset", 32'(0), 32'(busy));
        check_value("s_valid after reset", 32'(0), 32'(s_valid));
        check_value("piece_count after reset", 32'(0), 32'(piece_count));
        finish_test();
        start_test("random_commands");
        for (int i = 0; i < NUM_COMMANDS; i++)
        begin
            current_command = i;
            run_command();
        end
        finish_test();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== design/burst_bridge_top.sv ====
// Burst count bridge top level
// Connects a master that issues long bursts to a slave port with a
// smaller burst limit. The tracker owns the handshake and the gearbox
// splits each command into legal slave bursts

`timescale 1ns/100ps

module burst_bridge_top
    import burst_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH         = DEFAULT_ADDR_WIDTH,
    parameter int MASTER_BURST_WIDTH = DEFAULT_MASTER_BURST_WIDTH,
    parameter int SLAVE_BURST_WIDTH  = DEFAULT_SLAVE_BURST_WIDTH,
    parameter int NATURAL_ALIGNMENT  = DEFAULT_NATURAL_ALIGNMENT
) (
    input  logic                          clk,
    input  logic                          reset_n,

    // Master command port
    input  logic                          m_new_req,
    input  logic [ADDR_WIDTH-1:0]         m_addr,
    input  logic [MASTER_BURST_WIDTH-1:0] m_burstcount,
    output logic                          busy,

    // Slave command port
    output logic                          s_valid,
    output logic [ADDR_WIDTH-1:0]         s_addr,
    output logic [SLAVE_BURST_WIDTH-1:0]  s_burstcount,
    output logic                          s_last,
    input  logic                          s_accept,
    output logic [PIECE_COUNT_WIDTH-1:0]  piece_count
);

    slave_cmd_if #(
        .ADDR_WIDTH         (ADDR_WIDTH),
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH  (SLAVE_BURST_WIDTH)
    ) cmd_bus ();

    burst_cmd_tracker #(
        .ADDR_WIDTH         (ADDR_WIDTH),
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH)
    ) tracker_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .m_new_req    (m_new_req),
        .m_addr       (m_addr),
        .m_burstcount (m_burstcount),
        .busy         (busy),
        .s_valid      (s_valid),
        .s_accept     (s_accept),
        .piece_count  (piece_count),
        .cmd          (cmd_bus.tracker)
    );

    burst_gearbox #(
        .ADDR_WIDTH         (ADDR_WIDTH),
        .MASTER_BURST_WIDTH (MASTER_BURST_WIDTH),
        .SLAVE_BURST_WIDTH  (SLAVE_BURST_WIDTH),
        .NATURAL_ALIGNMENT  (NATURAL_ALIGNMENT)
    ) gearbox_i (
        .clk     (clk),
        .reset_n (reset_n),
        .cmd     (cmd_bus.gearbox),
        .s_addr  (s_addr)
    );

    // Size of the piece on offer and whether it ends the command
    assign s_burstcount = cmd_bus.burstcount;
    assign s_last       = cmd_bus.req_complete;

endmodule

// ==== design/burst_cmd_tracker.sv ====
// Master command tracker
// Takes one master command at a time, keeps the bridge busy while its
// pieces drain to the slave, and counts the pieces that were accepted

`timescale 1ns/100ps

module burst_cmd_tracker
    import burst_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH         = 32,
    parameter int MASTER_BURST_WIDTH = 7
) (
    input  logic                          clk,
    input  logic                          reset_n,

    // Master side
    input  logic                          m_new_req,
    input  logic [ADDR_WIDTH-1:0]         m_addr,
    input  logic [MASTER_BURST_WIDTH-1:0] m_burstcount,
    output logic                          busy,

    // Slave handshake
    output logic                          s_valid,
    input  logic                          s_accept,
    output logic [PIECE_COUNT_WIDTH-1:0]  piece_count,

    // Command channel to the gearbox
    slave_cmd_if.tracker                  cmd
);

    // A piece really moves only when one is on offer
    logic accepted;

    assign accepted = s_accept & s_valid;

    // The gearbox loads the command on the strobe edge itself,
    // which gives the one-cycle latency to the first s_valid
    assign cmd.new_req        = m_new_req;
    assign cmd.addr           = m_addr;
    assign cmd.cmd_burstcount = m_burstcount;
    assign cmd.accept         = accepted;

    // Busy is the whole tracker state. It rises on the strobe and falls
    // after the slave takes the piece that ends the command
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= 1'b0;
        end
        else if (m_new_req)
        begin
            busy <= 1'b1;
        end
        else if (accepted && cmd.req_complete)
        begin
            busy <= 1'b0;
        end
    end

    // A piece is on offer for exactly as long as the command is open
    assign s_valid = busy;

    // Pieces accepted for the current command. The count is kept after
    // the last piece so it can be read until the next command arrives
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            piece_count <= '0;
        end
        else if (m_new_req)
        begin
            piece_count <= '0;
        end
        else if (accepted)
        begin
            piece_count <= piece_count + PIECE_COUNT_WIDTH'(1);
        end
    end

endmodule

// ==== design/burst_gearbox.sv ====
// Burst count gearbox
// Holds the unsent part of a master command and carves it into bursts
// that the slave can take, either capped at the slave maximum or split
// into naturally aligned powers of two

`timescale 1ns/100ps

module burst_gearbox
    import burst_cfg_pkg::*;
    import burst_rule_pkg::*;
#(
    parameter int ADDR_WIDTH         = 32,
    parameter int MASTER_BURST_WIDTH = 7,
    parameter int SLAVE_BURST_WIDTH  = 3,
    parameter int NATURAL_ALIGNMENT  = 1
) (
    input  logic                  clk,
    input  logic                  reset_n,
    slave_cmd_if.gearbox          cmd,
    output logic [ADDR_WIDTH-1:0] s_addr
);

    // Largest burst the slave accepts, in the wide rule format
    localparam logic [MAX_BURST_WIDTH-1:0] SLAVE_MAX_BURST =
        MAX_BURST_WIDTH'(1) << (SLAVE_BURST_WIDTH - 1);

    // Flits of the current master command not yet handed to the slave
    logic [MASTER_BURST_WIDTH-1:0] remaining;

    // Highest set bit of remaining, kept registered so the aligned
    // size search does not sit behind a priority chain every cycle
    logic [MASTER_BURST_WIDTH-1:0] remaining_mask;

    // Count of the piece on offer, widened to the master width
    logic [MASTER_BURST_WIDTH-1:0] issued;
    logic [MASTER_BURST_WIDTH-1:0] remaining_next;

    // Wide copies used by the rule functions
    logic [MAX_BURST_WIDTH-1:0]    remaining_wide;
    logic [MAX_BURST_WIDTH-1:0]    mask_wide;
    logic [MAX_BURST_WIDTH-1:0]    addr_low;
    logic [MAX_BURST_WIDTH-1:0]    legal_burst;

    assign issued         = MASTER_BURST_WIDTH'(cmd.burstcount);
    assign remaining_next = remaining - issued;

    // Zero-extend into the rule width; the address is cut to its low bits
    // since only those can limit a burst of at most MAX_BURST_WIDTH bits
    assign remaining_wide = MAX_BURST_WIDTH'(remaining);
    assign mask_wide      = MAX_BURST_WIDTH'(remaining_mask);
    assign addr_low       = MAX_BURST_WIDTH'(s_addr);

    // Remaining count and its highest-one mask
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            remaining      <= '0;
            remaining_mask <= '0;
        end
        else if (cmd.new_req)
        begin
            // A new command replaces whatever was left
            remaining      <= cmd.cmd_burstcount;
            remaining_mask <= MASTER_BURST_WIDTH'(
                only_highest_one(MAX_BURST_WIDTH'(cmd.cmd_burstcount)));
        end
        else if (cmd.accept)
        begin
            // The slave took a piece, so drop it from the remainder
            remaining      <= remaining_next;
            remaining_mask <= MASTER_BURST_WIDTH'(
                only_highest_one(MAX_BURST_WIDTH'(remaining_next)));
        end
    end

    // Start address of the piece on offer
    always_ff @(posedge clk)
    begin
        if (cmd.new_req)
        begin
            s_addr <= cmd.addr;
        end
        else if (cmd.accept)
        begin
            // Next piece starts right after the one just accepted
            s_addr <= s_addr + ADDR_WIDTH'(cmd.burstcount);
        end
    end

    // Pick the size of the piece on offer
    always_comb
    begin
        if (NATURAL_ALIGNMENT != 0)
        begin
            // Power of two, bounded by the address alignment and by the
            // largest power of two that still fits in the remainder
            legal_burst = aligned_burst_max(mask_wide, addr_low, SLAVE_BURST_WIDTH);
        end
        else
        begin
            // Any size, just not above the slave maximum
            legal_burst = capped_burst(remaining_wide, SLAVE_MAX_BURST);
        end
    end

    // The legal burst never exceeds the slave maximum, so it fits
    assign cmd.burstcount = SLAVE_BURST_WIDTH'(legal_burst);

    // This piece empties the remainder, so the command ends with it
    assign cmd.req_complete = (legal_burst == remaining_wide);

endmodule

// ==== design/slave_cmd_if.sv ====
// Slave command channel between the command tracker and the gearbox
// Carries the incoming master command down to the gearbox and the
// legal slave burst back up, along with the accept and completion flags

`timescale 1ns/100ps

interface slave_cmd_if #(
    parameter int ADDR_WIDTH         = 32,
    parameter int MASTER_BURST_WIDTH = 7,
    parameter int SLAVE_BURST_WIDTH  = 3
);

    // One-cycle strobe that loads a new master command
    logic                          new_req;
    logic [ADDR_WIDTH-1:0]         addr;
    logic [MASTER_BURST_WIDTH-1:0] cmd_burstcount;

    // The slave took the piece on offer
    logic                          accept;

    // Legal burst count of the piece on offer
    logic [SLAVE_BURST_WIDTH-1:0]  burstcount;

    // The piece on offer finishes the master command
    logic                          req_complete;

    modport tracker (
        output new_req, addr, cmd_burstcount, accept,
        input  req_complete
    );

    modport gearbox (
        input  new_req, addr, cmd_burstcount, accept,
        output burstcount, req_complete
    );

endinterface

// ==== design/burst_rule_pkg.sv ====
// Burst splitting rules
// Pure functions that pick the size of the next slave burst from the
// remaining master count and the current address. They work on the
// widest supported burst field, so callers zero-extend their counts

package burst_rule_pkg;

    import burst_cfg_pkg::*;

    // Keep only the top set bit of a count and clear everything below it
    // The result is the largest power of two not above the count
    function automatic logic [MAX_BURST_WIDTH-1:0] only_highest_one(
        input logic [MAX_BURST_WIDTH-1:0] count
    );
        logic [MAX_BURST_WIDTH-1:0] mask;
        logic                       found;
        mask  = '0;
        found = 1'b0;
        for (int i = MAX_BURST_WIDTH - 1; i >= 0; i--)
        begin
            mask[i] = count[i] & !found;
            found   = found | count[i];
        end
        return mask;
    endfunction

    // Largest naturally aligned burst for a count mask and an address
    // The lowest set bit of either one bounds the burst, and limit_width
    // caps it at the slave maximum of 2^(limit_width-1)
    function automatic logic [MAX_BURST_WIDTH-1:0] aligned_burst_max(
        input logic [MAX_BURST_WIDTH-1:0] count,
        input logic [MAX_BURST_WIDTH-1:0] addr_low,
        input int                         limit_width
    );
        logic [MAX_BURST_WIDTH-1:0] result;
        logic                       found;
        // Fall back to the slave maximum when no low bit is set
        result = MAX_BURST_WIDTH'(1) << (limit_width - 1);
        found  = 1'b0;
        for (int i = 0; i < MAX_BURST_WIDTH; i++)
        begin
            if (!found && (i < limit_width) && (count[i] || addr_low[i]))
            begin
                result = MAX_BURST_WIDTH'(1) << i;
                found  = 1'b1;
            end
        end
        return result;
    endfunction

    // Smaller of the remaining count and the slave maximum
    function automatic logic [MAX_BURST_WIDTH-1:0] capped_burst(
        input logic [MAX_BURST_WIDTH-1:0] count,
        input logic [MAX_BURST_WIDTH-1:0] slave_max
    );
        return (count > slave_max) ? slave_max : count;
    endfunction

endpackage

// ==== design/burst_cfg_pkg.sv ====
// Burst bridge configuration constants
// Default widths and the alignment mode that the top level and the
// testbench start from, plus the fixed limits of the burst arithmetic

package burst_cfg_pkg;

    // Address width, counted in flits
    localparam int DEFAULT_ADDR_WIDTH = 32;

    // Master burst count field, bursts of up to 64 flits
    localparam int DEFAULT_MASTER_BURST_WIDTH = 7;

    // Slave burst count field, bursts of up to 4 flits
    localparam int DEFAULT_SLAVE_BURST_WIDTH = 3;

    // Slave bursts are naturally aligned powers of two by default
    localparam int DEFAULT_NATURAL_ALIGNMENT = 1;

    // Widest burst count field that the rule functions handle
    localparam int MAX_BURST_WIDTH = 16;

    // Width of the per-command piece counter
    localparam int PIECE_COUNT_WIDTH = 16;

endpackage
